// ==== design/fetchPkg.sv ====
// fetch stage 1 shared definitions
// widths, control type encoding and btb entry layout
package fetchPkg;

    // fetch address and target width
    localparam int pcW = 32;

    // raw instruction word
    localparam int instW = 32;

    // each lane sits one instruction further on
    localparam int instBytes = 4;
    localparam int offW = $clog2(instBytes);

    // partial tag kept per btb entry
    localparam int tagW = 10;

    // bimodal saturating counter
    localparam int ctrW = 2;

    typedef logic [pcW-1:0]   pcT;
    typedef logic [instW-1:0] instT;

    // control type as stored in the btb and sent in packets
    typedef enum logic [1:0]
    {
        brCall   = 2'd0,
        brReturn = 2'd1,
        brJump   = 2'd2,
        brCond   = 2'd3
    } brTypeE;

    // one btb entry
    // valid also serves as the lane hit flag on the read side
    typedef struct packed
    {
        logic            valid;
        logic [tagW-1:0] tag;
        brTypeE          brType;
        pcT              target;
    } btbEntryT;

endpackage

// ==== design/fetchIfs.sv ====
// interfaces inside fetch stage 1
// in-order predictor update, recovery from later stages, ras commands
`timescale 1ns/1ps

interface updateIf import fetchPkg::*; ();
    pcT              updatePc;
    pcT              updateNpc;
    brTypeE          updateBrType;
    logic            updateDir;
    logic [ctrW-1:0] updateCounter;
    logic            updateEn;

    // btb and counter table only listen
    modport recv (input updatePc, updateNpc, updateBrType, updateDir,
                  updateCounter, updateEn);
endinterface

interface recoverIf import fetchPkg::*; ();
    // execute redirect
    logic recoverFlag;
    pcT   recoverPc;
    // fetch stage 2 redirect, possibly for a call or return the btb missed
    logic fs2RecoverFlag;
    pcT   fs2RecoverPc;
    logic fs2MissedCall;
    pcT   fs2CallPc;
    logic fs2MissedReturn;

    modport recv (input recoverFlag, recoverPc, fs2RecoverFlag, fs2RecoverPc,
                  fs2MissedCall, fs2CallPc, fs2MissedReturn);
endinterface

interface rasIf import fetchPkg::*; ();
    logic push;
    logic pop;
    pcT   pushAddr;
    pcT   tos;

    // predicted commands come from the lane redirect logic
    modport redirect (output push, pop, pushAddr, input tos);
    modport stack (input push, pop, pushAddr, output tos);
endinterface

// ==== design/branchTargetBuffer.sv ====
// direct-mapped branch target buffer
// one combinational lookup per fetch lane, one write from the update port
// a miss shows up as an all-zero entry
`timescale 1ns/1ps

module branchTargetBuffer import fetchPkg::*;
#(
    parameter int fetchWidth = 2,
    parameter int btbEntries = 16
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  pcT                        pc_i,
    updateIf.recv                     updPort,
    output btbEntryT [fetchWidth-1:0] entry_o
);

    localparam int idxW = $clog2(btbEntries);

    logic [btbEntries-1:0] validQ;
    logic [tagW-1:0]       tagMem    [btbEntries];
    brTypeE                typeMem   [btbEntries];
    pcT                    targetMem [btbEntries];

    logic                  btbWrite;
    logic [idxW-1:0]       wrIdx;

    // allocate only on a taken outcome
    assign btbWrite = updPort.updateEn & updPort.updateDir;
    // index from the bits right above the byte offset
    assign wrIdx    = updPort.updatePc[offW +: idxW];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            validQ <= '0;
        else if (btbWrite)
            validQ[wrIdx] <= 1'b1;
    end

    // tag, type and target written together
    always_ff @(posedge clk)
    begin
        if (btbWrite)
        begin
            tagMem[wrIdx]    <= updPort.updatePc[offW+idxW +: tagW];
            typeMem[wrIdx]   <= updPort.updateBrType;
            targetMem[wrIdx] <= updPort.updateNpc;
        end
    end

    // each lane looks up its own address
    always_comb
    begin
        pcT              laneAddr;
        logic [idxW-1:0] rdIdx;
        logic            hit;
        for (int l = 0; l < fetchWidth; l++)
        begin
            laneAddr   = pc_i + pcT'(instBytes * l);
            rdIdx      = laneAddr[offW +: idxW];
            hit        = validQ[rdIdx] && (tagMem[rdIdx] == laneAddr[offW+idxW +: tagW]);
            entry_o[l] = '0;
            if (hit)
            begin
                entry_o[l].valid  = 1'b1;
                entry_o[l].tag    = tagMem[rdIdx];
                entry_o[l].brType = typeMem[rdIdx];
                entry_o[l].target = targetMem[rdIdx];
            end
        end
    end

endmodule

// ==== design/bimodalPredictor.sv ====
// bimodal direction predictor
// table of 2-bit counters, read per lane, written from the update port
`timescale 1ns/1ps

module bimodalPredictor import fetchPkg::*;
#(
    parameter int fetchWidth = 2,
    parameter int bpEntries  = 64
)
(
    input  logic                             clk,
    input  logic                             reset,
    input  pcT                               pc_i,
    updateIf.recv                            updPort,
    output logic [fetchWidth-1:0]            predDir_o,
    output logic [fetchWidth-1:0][ctrW-1:0]  predCounter_o
);

    localparam int idxW = $clog2(bpEntries);
    // all counters start weakly not taken
    localparam logic [ctrW-1:0] weakNotTaken = 2'b01;

    logic [ctrW-1:0] ctrQ [bpEntries];
    logic            bpWrite;
    logic [idxW-1:0] wrIdx;

    // only conditional branches train the counters
    assign bpWrite = updPort.updateEn && (updPort.updateBrType == brCond);
    assign wrIdx   = updPort.updatePc[offW +: idxW];

    // new counter value is computed upstream, stored as given
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            for (int i = 0; i < bpEntries; i++)
                ctrQ[i] <= weakNotTaken;
        end
        else if (bpWrite)
        begin
            ctrQ[wrIdx] <= updPort.updateCounter;
        end
    end

    // direction is the counter msb
    always_comb
    begin
        pcT laneAddr;
        for (int l = 0; l < fetchWidth; l++)
        begin
            laneAddr         = pc_i + pcT'(instBytes * l);
            predCounter_o[l] = ctrQ[laneAddr[offW +: idxW]];
            predDir_o[l]     = predCounter_o[l][ctrW-1];
        end
    end

endmodule

// ==== design/returnAddressStack.sv ====
// return address stack
// circular array with a top pointer, overflow wraps over old entries
// stage-2 missed call/return beat the predicted push/pop
`timescale 1ns/1ps

module returnAddressStack import fetchPkg::*;
#(
    parameter int rasDepth = 8
)
(
    input  logic  clk,
    input  logic  reset,
    input  logic  stall_i,
    recoverIf.recv recPort,
    rasIf.stack   rasPort
);

    localparam int ptrW = $clog2(rasDepth);

    pcT              stackQ [rasDepth];
    logic [ptrW-1:0] topQ;
    logic [ptrW-1:0] topInc;
    logic            doPush;
    logic            doPop;
    pcT              pushVal;

    // top entry always visible
    assign rasPort.tos = stackQ[topQ];
    assign topInc      = topQ + 1'b1;

    // command select
    always_comb
    begin
        doPush  = 1'b0;
        doPop   = 1'b0;
        pushVal = rasPort.pushAddr;
        if (recPort.fs2MissedCall)
        begin
            // call the btb missed, its return address comes from stage 2
            doPush  = 1'b1;
            pushVal = recPort.fs2CallPc;
        end
        else if (recPort.fs2MissedReturn)
        begin
            doPop = 1'b1;
        end
        else if (!recPort.recoverFlag && !stall_i)
        begin
            // predicted commands from the current fetch group
            doPush = rasPort.push;
            doPop  = rasPort.pop;
        end
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            topQ <= '0;
            for (int i = 0; i < rasDepth; i++)
                stackQ[i] <= '0;
        end
        else if (doPush)
        begin
            stackQ[topInc] <= pushVal;
            topQ           <= topInc;
        end
        else if (doPop)
        begin
            topQ <= topQ - 1'b1;
        end
    end

endmodule

// ==== design/laneRedirect.sv ====
// lane redirect logic
// per-lane taken vector, first taken lane picks the predicted next pc
// raises ras push/pop for calls and returns, builds stage-2 packet fields
`timescale 1ns/1ps

module laneRedirect import fetchPkg::*;
#(
    parameter int fetchWidth = 2
)
(
    input  pcT                        pc_i,
    input  btbEntryT [fetchWidth-1:0] entry_i,
    input  logic [fetchWidth-1:0]     predDir_i,
    input  instT [fetchWidth-1:0]     inst_i,
    input  logic                      instValid_i,
    rasIf.redirect                    rasPort,
    output pcT                        predNpc_o,
    output pcT [fetchWidth-1:0]       instPc_o,
    output pcT [fetchWidth-1:0]       pktPc_o,
    output instT [fetchWidth-1:0]     pktInst_o,
    output logic [fetchWidth-1:0]     pktValid_o,
    output logic [fetchWidth-1:0]     pktBtbHit_o,
    output brTypeE [fetchWidth-1:0]   pktBrType_o,
    output pcT [fetchWidth-1:0]       pktTakenPc_o,
    output logic [fetchWidth-1:0]     pktPredDir_o,
    output logic                      fs1Ready_o
);

    pcT [fetchWidth-1:0]   lanePc;
    logic [fetchWidth-1:0] takenVec;

    // lane addresses and taken lanes
    // unconditional hits always redirect, conditionals need a taken counter
    always_comb
    begin
        for (int l = 0; l < fetchWidth; l++)
        begin
            lanePc[l]   = pc_i + pcT'(instBytes * l);
            takenVec[l] = instValid_i & entry_i[l].valid &
                          ((entry_i[l].brType != brCond) | predDir_i[l]);
        end
    end

    // first taken lane wins
    always_comb
    begin
        logic found;
        found            = 1'b0;
        // nothing valid means refetch the same group
        predNpc_o        = instValid_i ? pc_i + pcT'(instBytes * fetchWidth) : pc_i;
        rasPort.push     = 1'b0;
        rasPort.pop      = 1'b0;
        rasPort.pushAddr = lanePc[0] + pcT'(instBytes);
        for (int l = 0; l < fetchWidth; l++)
        begin
            if (takenVec[l] && !found)
            begin
                found = 1'b1;
                if (entry_i[l].brType == brReturn)
                begin
                    predNpc_o   = rasPort.tos;
                    rasPort.pop = 1'b1;
                end
                else
                begin
                    predNpc_o = entry_i[l].target;
                    // return lands right after the call
                    if (entry_i[l].brType == brCall)
                    begin
                        rasPort.push     = 1'b1;
                        rasPort.pushAddr = lanePc[l] + pcT'(instBytes);
                    end
                end
            end
        end
    end

    // stage-2 packet fields
    always_comb
    begin
        for (int l = 0; l < fetchWidth; l++)
        begin
            pktInst_o[l]    = instValid_i ? inst_i[l] : '0;
            pktBtbHit_o[l]  = entry_i[l].valid;
            pktBrType_o[l]  = entry_i[l].brType;
            // returns take their target from the ras
            pktTakenPc_o[l] = (entry_i[l].brType == brReturn) ? rasPort.tos
                                                               : entry_i[l].target;
        end
    end

    assign instPc_o     = lanePc;
    assign pktPc_o      = lanePc;
    assign pktValid_o   = {fetchWidth{instValid_i}};
    assign pktPredDir_o = predDir_i;
    assign fs1Ready_o   = instValid_i;

endmodule

// ==== design/pcSequencer.sv ====
// fetch pc register and next-pc priority
// execute recovery, then stage-2 recovery, then prediction, else hold
// also flops the fetch request
`timescale 1ns/1ps

module pcSequencer import fetchPkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  pcT     startPc_i,
    input  logic   stall_i,
    input  pcT     predNpc_i,
    recoverIf.recv recPort,
    input  pcT     rasTos_i,
    output pcT     pc_o,
    output logic   fetchReq_o
);

    pcT pcQ;
    pcT nextPc;

    // recoveries are not blocked by stall
    always_comb
    begin
        if (recPort.recoverFlag)
            nextPc = recPort.recoverPc;
        else if (recPort.fs2RecoverFlag)
            // missed return resumes at the ras top
            nextPc = recPort.fs2MissedReturn ? rasTos_i : recPort.fs2RecoverPc;
        else if (!stall_i)
            nextPc = predNpc_i;
        else
            nextPc = pcQ;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            pcQ <= startPc_i;
        else
            pcQ <= nextPc;
    end

    // request goes high one edge after reset drops
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            fetchReq_o <= 1'b0;
        else
            fetchReq_o <= 1'b1;
    end

    assign pc_o = pcQ;

endmodule

// ==== design/fetchStage1Top.sv ====
// fetch stage 1 top level
// pc sequencer, btb, bimodal counters and ras around the lane redirect logic
// plain ports outside, interfaces between the blocks
`timescale 1ns/1ps

module fetchStage1Top import fetchPkg::*;
#(
    parameter int fetchWidth = 2,
    parameter int btbEntries = 16,
    parameter int bpEntries  = 64,
    parameter int rasDepth   = 8
)
(
    input  logic                            clk,
    input  logic                            reset,
    input  pcT                              startPc_i,
    input  logic                            stall_i,
    // recovery
    input  logic                            recoverFlag_i,
    input  pcT                              recoverPc_i,
    input  logic                            fs2RecoverFlag_i,
    input  pcT                              fs2RecoverPc_i,
    input  logic                            fs2MissedCall_i,
    input  pcT                              fs2CallPc_i,
    input  logic                            fs2MissedReturn_i,
    // in-order update
    input  pcT                              updatePc_i,
    input  pcT                              updateNpc_i,
    input  brTypeE                          updateBrType_i,
    input  logic                            updateDir_i,
    input  logic [ctrW-1:0]                 updateCounter_i,
    input  logic                            updateEn_i,
    // instruction source
    input  instT [fetchWidth-1:0]           inst_i,
    input  logic                            instValid_i,
    output logic                            fetchReq_o,
    output pcT [fetchWidth-1:0]             instPc_o,
    output logic                            fs1Ready_o,
    output pcT                              addrRas_o,
    // packets to stage 2
    output pcT [fetchWidth-1:0]             pktPc_o,
    output instT [fetchWidth-1:0]           pktInst_o,
    output logic [fetchWidth-1:0]           pktValid_o,
    output logic [fetchWidth-1:0]           pktBtbHit_o,
    output brTypeE [fetchWidth-1:0]         pktBrType_o,
    output pcT [fetchWidth-1:0]             pktTakenPc_o,
    output logic [fetchWidth-1:0]           pktPredDir_o,
    output logic [fetchWidth-1:0][ctrW-1:0] pktPredCounter_o
);

    pcT                        pc;
    pcT                        predNpc;
    btbEntryT [fetchWidth-1:0] btbEntry;
    logic [fetchWidth-1:0]     predDir;

    updateIf  updBus ();
    recoverIf recBus ();
    rasIf     rasBus ();

    assign updBus.updatePc      = updatePc_i;
    assign updBus.updateNpc     = updateNpc_i;
    assign updBus.updateBrType  = updateBrType_i;
    assign updBus.updateDir     = updateDir_i;
    assign updBus.updateCounter = updateCounter_i;
    assign updBus.updateEn      = updateEn_i;

    assign recBus.recoverFlag     = recoverFlag_i;
    assign recBus.recoverPc       = recoverPc_i;
    assign recBus.fs2RecoverFlag  = fs2RecoverFlag_i;
    assign recBus.fs2RecoverPc    = fs2RecoverPc_i;
    assign recBus.fs2MissedCall   = fs2MissedCall_i;
    assign recBus.fs2CallPc       = fs2CallPc_i;
    assign recBus.fs2MissedReturn = fs2MissedReturn_i;

    // stage 2 needs the ras top for returns the btb missed
    assign addrRas_o = rasBus.tos;

    pcSequencer pcSequencer_inst (
        .clk(clk), .reset(reset), .startPc_i(startPc_i), .stall_i(stall_i),
        .predNpc_i(predNpc), .recPort(recBus), .rasTos_i(rasBus.tos),
        .pc_o(pc), .fetchReq_o(fetchReq_o)
    );

    branchTargetBuffer #(.fetchWidth(fetchWidth), .btbEntries(btbEntries)) btb_inst (
        .clk(clk), .reset(reset), .pc_i(pc), .updPort(updBus), .entry_o(btbEntry)
    );

    bimodalPredictor #(.fetchWidth(fetchWidth), .bpEntries(bpEntries)) bimodal_inst (
        .clk(clk), .reset(reset), .pc_i(pc), .updPort(updBus),
        .predDir_o(predDir), .predCounter_o(pktPredCounter_o)
    );

    returnAddressStack #(.rasDepth(rasDepth)) ras_inst (
        .clk(clk), .reset(reset), .stall_i(stall_i), .recPort(recBus), .rasPort(rasBus)
    );

    laneRedirect #(.fetchWidth(fetchWidth)) laneRedirect_inst (
        .pc_i(pc), .entry_i(btbEntry), .predDir_i(predDir), .inst_i(inst_i),
        .instValid_i(instValid_i), .rasPort(rasBus), .predNpc_o(predNpc),
        .instPc_o(instPc_o), .pktPc_o(pktPc_o), .pktInst_o(pktInst_o),
        .pktValid_o(pktValid_o), .pktBtbHit_o(pktBtbHit_o), .pktBrType_o(pktBrType_o),
        .pktTakenPc_o(pktTakenPc_o), .pktPredDir_o(pktPredDir_o), .fs1Ready_o(fs1Ready_o)
    );

endmodule

// ==== include/fetchTbModel.svh ====
// reference model of fetch stage 1 for the testbench
// mirrors btb, counters, ras and pc, predicts one fetch group per cycle
`ifndef FETCH_TB_MODEL_SVH
`define FETCH_TB_MODEL_SVH

logic            mBtbV   [btbN];
logic [tagW-1:0] mBtbTag [btbN];
brTypeE          mBtbTy  [btbN];
pcT              mBtbTg  [btbN];
logic [ctrW-1:0] mCtr    [bpN];
pcT              mRas    [rasN];
logic [rasPtrW-1:0] mTop;
pcT              mPc;
logic            mReq;

// expected outputs for the current cycle
pcT              eLanePc [fW];
logic            eHit    [fW];
brTypeE          eType   [fW];
pcT              eTakenPc[fW];
logic [ctrW-1:0] eCtr    [fW];
pcT              eNpc;
logic            ePush;
logic            ePop;
pcT              ePushAddr;

task automatic modelReset();
    for (int i = 0; i < btbN; i++)
        mBtbV[i] = 1'b0;
    for (int i = 0; i < bpN; i++)
        mCtr[i] = 2'b01;
    for (int i = 0; i < rasN; i++)
        mRas[i] = '0;
    mTop = '0;
    mPc  = startPc;
    mReq = 1'b0;
endtask

task automatic modelPredict();
    int  bi;
    logic found;
    logic taken;
    found = 1'b0;
    eNpc  = instValid ? mPc + pcT'(instBytes * fW) : mPc;
    ePush = 1'b0;
    ePop  = 1'b0;
    ePushAddr = '0;
    for (int l = 0; l < fW; l++)
    begin
        eLanePc[l] = mPc + pcT'(4 * l);
        bi = int'(eLanePc[l][5:2]);
        eHit[l]  = mBtbV[bi] && (mBtbTag[bi] == eLanePc[l][15:6]);
        // a miss reads back as an all-zero entry
        eType[l] = eHit[l] ? mBtbTy[bi] : brCall;
        eCtr[l]  = mCtr[int'(eLanePc[l][7:2])];
        eTakenPc[l] = !eHit[l] ? pcT'(0) : (eType[l] == brReturn) ? mRas[mTop] : mBtbTg[bi];
        taken = instValid && eHit[l] && (eType[l] != brCond || eCtr[l][1]);
        if (taken && !found)
        begin
            found = 1'b1;
            eNpc  = eTakenPc[l];
            ePop  = (eType[l] == brReturn);
            ePush = (eType[l] == brCall);
            ePushAddr = eLanePc[l] + 32'd4;
        end
    end
endtask

// next state at the coming edge, from the inputs of this cycle
task automatic modelStep();
    pcT tos;
    tos = mRas[mTop];
    if (updateEn && updateDir)
    begin
        mBtbV[int'(updatePc[5:2])]   = 1'b1;
        mBtbTag[int'(updatePc[5:2])] = updatePc[15:6];
        mBtbTy[int'(updatePc[5:2])]  = updateBrType;
        mBtbTg[int'(updatePc[5:2])]  = updateNpc;
    end
    if (updateEn && updateBrType == brCond)
        mCtr[int'(updatePc[7:2])] = updateCounter;
    if (fs2MissedCall)
    begin
        mTop = mTop + 1'b1;
        mRas[mTop] = fs2CallPc;
    end
    else if (fs2MissedReturn)
        mTop = mTop - 1'b1;
    else if (!recoverFlag && !stall && ePush)
    begin
        mTop = mTop + 1'b1;
        mRas[mTop] = ePushAddr;
    end
    else if (!recoverFlag && !stall && ePop)
        mTop = mTop - 1'b1;
    if (recoverFlag)
        mPc = recoverPc;
    else if (fs2RecoverFlag)
        mPc = fs2MissedReturn ? tos : fs2RecoverPc;
    else if (!stall)
        mPc = eNpc;
    mReq = 1'b1;
endtask

`endif

// ==== verif/fetchTb.sv ====
// testbench for fetch stage 1
// directed and random fetch groups checked every cycle against a model
`timescale 1ns/1ps

module fetchTb import fetchPkg::*;;
    localparam int fW = 2;
    localparam int btbN = 16;
    localparam int bpN = 64;
    localparam int rasN = 8;
    localparam int rasPtrW = $clog2(rasN);
    localparam pcT startPc = 32'h0000_1000;
    localparam int randLen = 400;
    // reset, four directed tests of up to 40 cycles and the random run, plus margin
    localparam int cycleLimit = 4 + 4 * 40 + randLen + 100;

    logic clk, reset, stall, instValid, updateDir, updateEn;
    logic recoverFlag, fs2RecoverFlag, fs2MissedCall, fs2MissedReturn;
    pcT recoverPc, fs2RecoverPc, fs2CallPc, updatePc, updateNpc;
    brTypeE updateBrType;
    logic [ctrW-1:0] updateCounter;
    instT [fW-1:0] inst;
    logic fetchReq, fs1Ready;
    pcT addrRas;
    pcT [fW-1:0] instPc, pktPc, pktTakenPc;
    instT [fW-1:0] pktInst;
    logic [fW-1:0] pktValid, pktBtbHit, pktPredDir;
    brTypeE [fW-1:0] pktBrType;
    logic [fW-1:0][ctrW-1:0] pktPredCounter;

    // stimulus for the next cycle, applied at the rising edge
    logic nReset, nStall, nValid, nRec, nFs2, nMCall, nMRet, nUpdEn, nUpdDir;
    pcT nRecPc, nFs2Pc, nCallPc, nUpdPc, nUpdNpc;
    brTypeE nUpdTy;
    logic [ctrW-1:0] nUpdCtr;

    int cycles = 0;
    int testErr = 0;
    int totalErr = 0;
    int testsFailed = 0;
    int testsRun = 0;
    string curTest = "reset";

    `include "fetchTbModel.svh"

    fetchStage1Top #(.fetchWidth(fW), .btbEntries(btbN), .bpEntries(bpN), .rasDepth(rasN))
    fetchStage1Top_inst (
        .clk(clk), .reset(reset), .startPc_i(startPc), .stall_i(stall),
        .recoverFlag_i(recoverFlag), .recoverPc_i(recoverPc), .fs2RecoverFlag_i(fs2RecoverFlag),
        .fs2RecoverPc_i(fs2RecoverPc), .fs2MissedCall_i(fs2MissedCall), .fs2CallPc_i(fs2CallPc),
        .fs2MissedReturn_i(fs2MissedReturn), .updatePc_i(updatePc), .updateNpc_i(updateNpc),
        .updateBrType_i(updateBrType), .updateDir_i(updateDir), .updateCounter_i(updateCounter),
        .updateEn_i(updateEn), .inst_i(inst), .instValid_i(instValid), .fetchReq_o(fetchReq),
        .instPc_o(instPc), .fs1Ready_o(fs1Ready), .addrRas_o(addrRas), .pktPc_o(pktPc),
        .pktInst_o(pktInst), .pktValid_o(pktValid), .pktBtbHit_o(pktBtbHit),
        .pktBrType_o(pktBrType), .pktTakenPc_o(pktTakenPc), .pktPredDir_o(pktPredDir),
        .pktPredCounter_o(pktPredCounter)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycles++;
            if (cycles > cycleLimit)
            begin
                $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
                $display(">>> FAIL");
                $finish;
            end
        end
    end

    task automatic checkPc(string what, pcT exp, pcT act);
        if (exp !== act)
        begin
            $display("Fail %s %s: expected %h actual %h", curTest, what, exp, act);
            testErr++;
        end
    endtask

    task automatic checkType(string what, brTypeE exp, brTypeE act);
        if (exp !== act)
        begin
            $display("Fail %s %s: expected %s actual %s", curTest, what, exp.name(), act.name());
            testErr++;
        end
    endtask

    task automatic checkBits(string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act)
        begin
            $display("Fail %s %s: expected %h actual %h", curTest, what, exp, act);
            testErr++;
        end
    endtask

    task automatic checkOutputs();
        modelPredict();
        checkBits("fetchReq", 32'(mReq), 32'(fetchReq));
        checkBits("fs1Ready", 32'(instValid), 32'(fs1Ready));
        checkPc("addrRas", mRas[mTop], addrRas);
        for (int l = 0; l < fW; l++)
        begin
            checkPc("instPc", eLanePc[l], instPc[l]);
            checkPc("pktPc", eLanePc[l], pktPc[l]);
            checkBits("pktInst", instValid ? inst[l] : 32'd0, pktInst[l]);
            checkBits("pktValid", 32'(instValid), 32'(pktValid[l]));
            checkBits("pktBtbHit", 32'(eHit[l]), 32'(pktBtbHit[l]));
            checkType("pktBrType", eType[l], pktBrType[l]);
            checkPc("pktTakenPc", eTakenPc[l], pktTakenPc[l]);
            checkBits("pktPredDir", 32'(eCtr[l][1]), 32'(pktPredDir[l]));
            checkBits("pktPredCounter", 32'(eCtr[l]), 32'(pktPredCounter[l]));
        end
    endtask

    task automatic clearStim();
        {nStall, nRec, nFs2, nMCall, nMRet, nUpdEn, nUpdDir} = '0;
        nValid = 1'b1;
        {nRecPc, nFs2Pc, nCallPc, nUpdPc, nUpdNpc} = '0;
        nUpdTy = brJump;
        nUpdCtr = 2'b01;
    endtask

    // one cycle: drive at the rising edge, check and advance the model at the falling edge
    task automatic stepCycle();
        @(posedge clk);
        reset <= nReset;
        stall <= nStall;
        instValid <= nValid;
        recoverFlag <= nRec;
        recoverPc <= nRecPc;
        fs2RecoverFlag <= nFs2;
        fs2RecoverPc <= nFs2Pc;
        fs2MissedCall <= nMCall;
        fs2CallPc <= nCallPc;
        fs2MissedReturn <= nMRet;
        updateEn <= nUpdEn;
        updateDir <= nUpdDir;
        updatePc <= nUpdPc;
        updateNpc <= nUpdNpc;
        updateBrType <= nUpdTy;
        updateCounter <= nUpdCtr;
        inst <= {$urandom(), $urandom()};
        @(negedge clk);
        checkOutputs();
        if (reset)
            modelReset();
        else
            modelStep();
    endtask

    // one training write while the pc is held
    task automatic train(pcT pc, pcT npc, brTypeE ty, logic [ctrW-1:0] ctr);
        clearStim();
        nStall = 1'b1;
        {nUpdEn, nUpdDir} = 2'b11;
        nUpdPc = pc;
        nUpdNpc = npc;
        nUpdTy = ty;
        nUpdCtr = ctr;
        stepCycle();
    endtask

    task automatic redirectTo(pcT pc);
        clearStim();
        nRec = 1'b1;
        nRecPc = pc;
        stepCycle();
        clearStim();
    endtask

    task automatic endTest();
        testsRun++;
        totalErr += testErr;
        if (testErr != 0)
            testsFailed++;
        $display("test %s: %0d errors", curTest, testErr);
        testErr = 0;
    endtask

    initial
    begin
        void'($urandom(32'haf1b_53d2));
        {reset, stall, instValid, recoverFlag, fs2RecoverFlag} = 5'b10000;
        {fs2MissedCall, fs2MissedReturn, updateEn, updateDir} = '0;
        {recoverPc, fs2RecoverPc, fs2CallPc, updatePc, updateNpc} = '0;
        updateBrType = brJump;
        updateCounter = 2'b01;
        inst = '0;
        modelReset();
        clearStim();
        nReset = 1'b1;
        repeat (4) stepCycle();
        nReset = 1'b0;

        curTest = "sequential";
        checkBits("fetchReq in reset", 32'd0, 32'(fetchReq));
        for (int i = 0; i < 8; i++)
        begin
            nValid = !i[0];
            stepCycle();
        end
        checkBits("fetchReq after reset", 32'd1, 32'(fetchReq));
        checkPc("pc after 4 valid groups", startPc + 32'd32, instPc[0]);
        endTest();

        curTest = "training";
        train(32'h1008, 32'h1100, brJump, 2'b00);
        train(32'h1104, 32'h1200, brCond, 2'b11);
        train(32'h1200, 32'h1300, brCond, 2'b01);
        redirectTo(32'h1008);
        stepCycle();
        stepCycle();
        checkPc("jump target", 32'h1100, instPc[0]);
        stepCycle();
        checkPc("taken cond", 32'h1200, instPc[0]);
        stepCycle();
        checkPc("weak cond falls through", 32'h1208, instPc[0]);
        endTest();

        curTest = "callReturn";
        train(32'h2000, 32'h3000, brCall, 2'b00);
        train(32'h3004, 32'h0, brReturn, 2'b00);
        redirectTo(32'h2000);
        stepCycle();
        stepCycle();
        checkPc("call target", 32'h3000, instPc[0]);
        checkPc("pushed return", 32'h2004, addrRas);
        checkPc("return taken pc", 32'h2004, pktTakenPc[1]);
        stepCycle();
        checkPc("return target", 32'h2004, instPc[0]);
        {nFs2, nMCall} = 2'b11;
        nFs2Pc = 32'h5000;
        nCallPc = 32'h4444;
        stepCycle();
        clearStim();
        stepCycle();
        checkPc("missed call push", 32'h4444, addrRas);
        {nFs2, nMRet} = 2'b11;
        stepCycle();
        clearStim();
        stepCycle();
        checkPc("missed return pc", 32'h4444, instPc[0]);
        endTest();

        curTest = "priority";
        {nRec, nFs2} = 2'b11;
        nRecPc = 32'h2000;
        nFs2Pc = 32'h6000;
        stepCycle();
        clearStim();
        nStall = 1'b1;
        stepCycle();
        checkPc("recovery beats stage 2", 32'h2000, instPc[0]);
        stepCycle();
        stepCycle();
        checkPc("stall holds pc", 32'h2000, instPc[0]);
        // stack is back at its reset entry, the call at 0x2000 must not push
        checkPc("stall blocks push", 32'h0, addrRas);
        endTest();

        curTest = "random";
        for (int i = 0; i < randLen; i++)
        begin
            clearStim();
            nValid = ($urandom_range(0, 3) != 0);
            nStall = ($urandom_range(0, 7) == 0);
            nRec = ($urandom_range(0, 15) == 0);
            nRecPc = 32'h1000 + ($urandom_range(0, 255) << 2);
            nFs2 = ($urandom_range(0, 15) == 0);
            nFs2Pc = 32'h1000 + ($urandom_range(0, 255) << 2);
            nMCall = nFs2 && $urandom_range(0, 1);
            nMRet = nFs2 && !nMCall && $urandom_range(0, 1);
            nCallPc = 32'h1000 + ($urandom_range(0, 255) << 2);
            nUpdEn = 1'($urandom_range(0, 1));
            nUpdDir = 1'($urandom_range(0, 1));
            nUpdPc = 32'h1000 + ($urandom_range(0, 255) << 2);
            nUpdNpc = 32'h1000 + ($urandom_range(0, 255) << 2);
            nUpdTy = brTypeE'($urandom_range(0, 3));
            nUpdCtr = 2'($urandom_range(0, 3));
            stepCycle();
        end
        endTest();

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, totalErr);
        if (totalErr == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
design/fetchPkg.sv
design/fetchIfs.sv
design/branchTargetBuffer.sv
design/bimodalPredictor.sv
design/returnAddressStack.sv
design/laneRedirect.sv
design/pcSequencer.sv
design/fetchStage1Top.sv
verif/fetchTb.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' tb.f) include/fetchTbModel.svh

.PHONY: all run clean

all: run

obj_dir/VfetchTb: $(SRCS) tb.f
	verilator --binary -f tb.f --top-module fetchTb -o VfetchTb

sim.log: obj_dir/VfetchTb
	./obj_dir/VfetchTb > sim.log 2>&1 || true
	cat sim.log

run: sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log
